// ==== alu/vec_alu.sv ====
`timescale 1ns/10ps

module vec_alu
    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      valid,
    input  alu_func_e func,
    input  vrf_addr_t waddr_in,
    input  elem_t     data0,
    input  elem_t     data1,
    output logic      wb_we,
    output vrf_addr_t wb_waddr,
    output elem_t     wb_data
);

    elem_t result;

    // Element op ------------------
    always_comb begin
        case (func)
            ALU_ADD: result = data0 + data1;     // Wraps mod 2^64
            ALU_SUB: result = data0 - data1;
            ALU_AND: result = data0 & data1;
            ALU_OR:  result = data0 | data1;
            ALU_XOR: result = data0 ^ data1;
            default: result = '0;
        endcase
    end

    // Write enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= valid;
        end
    end

    // Result travels with its address
    always_ff @(posedge clk) begin
        if (valid) begin
            wb_waddr <= waddr_in;
            wb_data  <= result;
        end
    end

endmodule

// ==== common/vec_ctrl_pkg.sv ====
`include "vec_macros.svh"

package vec_ctrl_pkg;

    // Instruction opcodes, bits 5..0 of the word
    typedef enum logic [5:0] {
        OP_SETVL = `VEC_OPC_SETVL,
        OP_VADD  = `VEC_OPC_VADD,
        OP_VSUB  = `VEC_OPC_VSUB,
        OP_VAND  = `VEC_OPC_VAND,
        OP_VOR   = `VEC_OPC_VOR,
        OP_VXOR  = `VEC_OPC_VXOR,
        OP_VLD   = `VEC_OPC_VLD,
        OP_VST   = `VEC_OPC_VST
    } vec_op_e;

    // Sequencer FSM
    typedef enum logic [1:0] {
        ST_IDLE,            // Waiting for an instruction
        ST_RUN,             // Issuing one element per cycle
        ST_DRAIN,           // Writes still in flight
        ST_RESP             // Holding the response
    } seq_state_e;

    // Element-wise ALU functions
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_func_e;

endpackage

// ==== common/vec_macros.svh ====
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Vector geometry ---------------
`define VEC_LANES 8             // Elements per register, also the max vl
`define VEC_REGS  8             // Architectural vector registers

// Instruction fields ------------
`define VEC_OP_MSB  5
`define VEC_OP_LSB  0
`define VEC_VD_MSB  10          // Destination, or the source for a store
`define VEC_VD_LSB  8
`define VEC_VS1_MSB 13
`define VEC_VS1_LSB 11
`define VEC_VS2_MSB 16
`define VEC_VS2_LSB 14

// Opcode codes ------------------
`define VEC_OPC_SETVL 6'd1
`define VEC_OPC_VADD  6'd2
`define VEC_OPC_VSUB  6'd3
`define VEC_OPC_VAND  6'd4
`define VEC_OPC_VOR   6'd5
`define VEC_OPC_VXOR  6'd6
`define VEC_OPC_VLD   6'd7
`define VEC_OPC_VST   6'd8

`endif

// ==== common/vec_types_pkg.sv ====
package vec_types_pkg;

    // Data path
    typedef logic [63:0] elem_t;      // One vector element

    // Register file addressing
    typedef logic [2:0] vreg_t;       // Register number
    typedef logic [2:0] eidx_t;       // Element index inside a register

    // Register number in the upper bits, element index below
    typedef logic [5:0] vrf_addr_t;

    // 0 to 8, so one bit wider than an index
    typedef logic [3:0] vlen_t;

    // Instruction port
    typedef logic [31:0] word_t;      // Instruction word and rs1 value

    // Main memory, 64-bit words
    typedef logic [31:0] mem_addr_t;  // Word address, not byte

endpackage

// ==== list.f ====
+incdir+common
common/vec_types_pkg.sv
common/vec_ctrl_pkg.sv
src/elem_counter.sv
src/vec_sequencer.sv
vrf/vec_regfile.sv
alu/vec_alu.sv
src/vec_shell.sv
sim/tb_mem_model.sv
sim/tb_vec_shell.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_vec_shell -f list.f

out=$(./obj_dir/Vtb_vec_shell)
printf '%s\n' "$out"

# Exit status follows the final verdict line
printf '%s\n' "$out" | grep -qx 'Regression passed'

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/10ps

module tb_mem_model
    import vec_types_pkg::*;
#(
    parameter int AW = 8                    // 256 words
) (
    input  logic      clk,
    input  logic      re,
    input  mem_addr_t raddr,
    output elem_t     rdata,
    input  logic      we,
    input  mem_addr_t waddr,
    input  elem_t     wdata
);

    elem_t mem [2**AW];                     // 64-bit words, word addressed

    // Port side --------------------
    always @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr[AW-1:0]];    // Valid one cycle after re
        end
        // Write after the read, so a same-cycle read sees old data
        if (we) begin
            mem[waddr[AW-1:0]] = wdata;
        end
    end

    // Backdoor ---------------------
    function automatic void poke(input logic [AW-1:0] addr, input elem_t data);
        mem[addr] = data;
    endfunction

    function automatic elem_t peek(input logic [AW-1:0] addr);
        return mem[addr];                   // No clock, no latency
    endfunction

endmodule

// ==== sim/tb_vec_shell.sv ====
`timescale 1ns/10ps
`include "vec_macros.svh"

module tb_vec_shell
    import vec_types_pkg::*;
();

    localparam int TIMEOUT = 200;           // Cycles allowed per handshake wait

    logic      clk;
    logic      rst_n;
    logic      insn_valid;
    word_t     insn;
    word_t     rs1;
    logic      resp_ready;
    elem_t     mem_rdata;
    logic      insn_ready;
    logic      resp_valid;
    vlen_t     resp_vl;
    logic      mem_re;
    mem_addr_t mem_raddr;
    logic      mem_we;
    mem_addr_t mem_waddr;
    elem_t     mem_wdata;

    logic [31:0] rng_state;
    logic        seen_insn;                 // Any instruction accepted yet
    logic        timed_out;
    int          errors;
    int          checks;
    int          tests;
    int          failed_tests;

    // Shadow state
    vlen_t vl_sh;
    elem_t reg_sh [8][8];
    elem_t mem_sh [256];

    initial clk = 1'b0;
    always #5 clk = ~clk;

    vec_shell i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .insn_valid (insn_valid),
        .insn       (insn),
        .rs1        (rs1),
        .resp_ready (resp_ready),
        .mem_rdata  (mem_rdata),
        .insn_ready (insn_ready),
        .resp_valid (resp_valid),
        .resp_vl    (resp_vl),
        .mem_re     (mem_re),
        .mem_raddr  (mem_raddr),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata)
    );

    tb_mem_model #(.AW(8)) i_mem (
        .clk   (clk),
        .re    (mem_re),
        .raddr (mem_raddr),
        .rdata (mem_rdata),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata)
    );

    // Helpers ----------------------
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic elem_t rand_elem();
        return {xorshift32(), xorshift32()};
    endfunction

    function automatic word_t encode(input logic [5:0] op, input vreg_t vd,
                                     input vreg_t vs1, input vreg_t vs2);
        word_t w;
        w = '0;
        w[`VEC_OP_MSB:`VEC_OP_LSB]   = op;
        w[`VEC_VD_MSB:`VEC_VD_LSB]   = vd;
        w[`VEC_VS1_MSB:`VEC_VS1_LSB] = vs1;
        w[`VEC_VS2_MSB:`VEC_VS2_LSB] = vs2;
        return w;
    endfunction

    // Expected element result
    function automatic elem_t ref_alu(input logic [5:0] op, input elem_t a, input elem_t b);
        case (op)
            `VEC_OPC_VADD: return a + b;    // Wraps mod 2^64
            `VEC_OPC_VSUB: return a - b;
            `VEC_OPC_VAND: return a & b;
            `VEC_OPC_VOR:  return a | b;
            `VEC_OPC_VXOR: return a ^ b;
            default:       return '0;
        endcase
    endfunction

    // Shadow update once an instruction completes
    function automatic void model_insn(input logic [5:0] op, input vreg_t vd, input vreg_t vs1,
                                       input vreg_t vs2, input word_t r1);
        case (op)
            `VEC_OPC_SETVL: vl_sh = vlen_t'((r1 < 32'd8) ? r1 : 32'd8);
            `VEC_OPC_VADD, `VEC_OPC_VSUB, `VEC_OPC_VAND, `VEC_OPC_VOR, `VEC_OPC_VXOR: begin
                for (int i = 0; i < int'(vl_sh); i++) begin
                    reg_sh[vd][3'(i)] = ref_alu(op, reg_sh[vs1][3'(i)], reg_sh[vs2][3'(i)]);
                end
            end
            `VEC_OPC_VLD: begin
                for (int i = 0; i < int'(vl_sh); i++) begin
                    reg_sh[vd][3'(i)] = mem_sh[8'(r1 + 32'(i))];
                end
            end
            `VEC_OPC_VST: begin
                for (int i = 0; i < int'(vl_sh); i++) begin
                    mem_sh[8'(r1 + 32'(i))] = reg_sh[vd][3'(i)];
                end
            end
            default: ;                      // Unknown ops leave no trace
        endcase
    endfunction

    function automatic void flag_error(input string msg);
        $display("%0t: %s", $time, msg);
        errors++;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mem(input int lo, input int hi);
        for (int a = lo; a <= hi; a++) begin
            check_val($sformatf("mem[%0d]", a), i_mem.peek(8'(a)), mem_sh[8'(a)]);
        end
    endtask

    task automatic fill_random(input int lo, input int hi);
        elem_t d;
        for (int a = lo; a <= hi; a++) begin
            d = rand_elem();
            i_mem.poke(8'(a), d);
            mem_sh[8'(a)] = d;
        end
    endtask

    // Handshakes -------------------
    task automatic send_insn(input word_t word, input word_t r1);
        int n;
        if (timed_out) return;
        @(posedge clk);
        insn_valid <= 1'b1;
        insn       <= word;
        rs1        <= r1;
        n = 0;
        @(negedge clk);
        while (!insn_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);                     // Accepted on this edge
        insn_valid <= 1'b0;
        if (n >= TIMEOUT) begin
            flag_error("timeout, insn_ready never rose");
            timed_out = 1'b1;
        end
    endtask

    // Waits for resp_valid, holds resp_ready low a random while, then takes it
    task automatic take_resp(output vlen_t vl, output int waited, input int max_stall);
        int n;
        int stall;
        vl     = '0;
        waited = 0;
        if (timed_out) return;
        n = 0;
        @(negedge clk);
        while (!resp_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!resp_valid) begin
            flag_error("timeout, resp_valid never rose");
            timed_out = 1'b1;
            return;
        end
        waited = n;
        vl     = resp_vl;
        stall  = int'(xorshift32() % 32'(max_stall + 1));
        repeat (stall) @(negedge clk);
        @(posedge clk);
        resp_ready <= 1'b1;
        @(posedge clk);                     // Response completes here
        resp_ready <= 1'b0;
    endtask

    task automatic run_insn(input logic [5:0] op, input vreg_t vd, input vreg_t vs1,
                            input vreg_t vs2, input word_t r1, input int max_stall);
        vlen_t vl;
        int    waited;
        send_insn(encode(op, vd, vs1, vs2), r1);
        take_resp(vl, waited, max_stall);
        if (timed_out) return;
        model_insn(op, vd, vs1, vs2, r1);
        check_val("resp_vl", 64'(vl), 64'(vl_sh));
        if (op == `VEC_OPC_SETVL) begin
            check_val("resp_valid delay", 64'(waited), 64'd1);  // Second cycle after accept
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("PASS  %s", name);
        end else begin
            failed_tests++;
            $display("FAIL  %s", name);
        end
    endtask

    // Protocol checks ------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            seen_insn <= 1'b0;
        end else if (insn_valid && insn_ready) begin
            seen_insn <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(mem_re && mem_we))
        else flag_error("mem_re and mem_we high together");
    assert property (@(posedge clk) disable iff (!rst_n) !seen_insn |-> !mem_re && !mem_we)
        else flag_error("memory strobe before the first instruction");
    assert property (@(posedge clk) disable iff (!rst_n) insn_valid && insn_ready |=> !insn_ready)
        else flag_error("insn_ready high right after acceptance");
    assert property (@(posedge clk) disable iff (!rst_n)
                     !insn_ready && !(resp_valid && resp_ready) |=> !insn_ready)
        else flag_error("insn_ready rose before the response completed");
    assert property (@(posedge clk) disable iff (!rst_n)
                     resp_valid && resp_ready |=> insn_ready && !resp_valid)
        else flag_error("no return to idle after the response");
    assert property (@(posedge clk) disable iff (!rst_n)
                     resp_valid && !resp_ready |=> resp_valid && resp_vl == $past(resp_vl))
        else flag_error("resp_valid dropped or resp_vl moved while waiting");

    // Stimulus ---------------------
    initial begin
        int         e0;
        logic [5:0] op;
        rng_state    = 32'h13e8ee0c;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        rst_n        = 1'b0;
        insn_valid   = 1'b0;
        insn         = '0;
        rs1          = '0;
        resp_ready   = 1'b0;
        vl_sh        = 4'd8;
        for (int r = 0; r < 8; r++) begin
            for (int e = 0; e < 8; e++) begin
                reg_sh[r][e] = '0;
            end
        end
        fill_random(0, 255);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Set length, 1000 leaves vl at 8
        e0 = errors;
        @(negedge clk);
        check_val("resp_vl", 64'(resp_vl), 64'd8);
        run_insn(`VEC_OPC_SETVL, 3'd0, 3'd0, 3'd0, 32'd0, 2);
        run_insn(`VEC_OPC_SETVL, 3'd0, 3'd0, 3'd0, 32'd3, 2);
        run_insn(`VEC_OPC_SETVL, 3'd0, 3'd0, 3'd0, 32'd8, 2);
        run_insn(`VEC_OPC_SETVL, 3'd0, 3'd0, 3'd0, 32'd1000, 2);
        end_test("set length", e0);

        // Load and store round trip
        e0 = errors;
        run_insn(`VEC_OPC_VLD, 3'd2, 3'd0, 3'd0, 32'd16, 2);
        run_insn(`VEC_OPC_VST, 3'd2, 3'd0, 3'd0, 32'd100, 2);
        for (int i = 0; i < 8; i++) begin
            check_val($sformatf("mem[%0d]", 100 + i), i_mem.peek(8'(100 + i)),
                      mem_sh[8'(16 + i)]);
        end
        check_mem(0, 255);                  // Word 108 and the rest untouched
        end_test("load/store round trip", e0);

        // All five ALU functions, codes are consecutive
        e0 = errors;
        for (int k = 0; k < 5; k++) begin
            op = 6'(int'(`VEC_OPC_VADD) + k);
            fill_random(32, 47);
            run_insn(`VEC_OPC_VLD, 3'd3, 3'd0, 3'd0, 32'd32, 3);
            run_insn(`VEC_OPC_VLD, 3'd4, 3'd0, 3'd0, 32'd40, 3);
            run_insn(op, 3'd5, 3'd3, 3'd4, 32'd0, 3);
            run_insn(`VEC_OPC_VST, 3'd5, 3'd0, 3'd0, 32'(128 + 8 * k), 3);
            for (int i = 0; i < 8; i++) begin
                check_val($sformatf("mem[%0d]", 128 + 8 * k + i),
                          i_mem.peek(8'(128 + 8 * k + i)),
                          ref_alu(op, mem_sh[8'(32 + i)], mem_sh[8'(40 + i)]));
            end
        end
        check_mem(0, 255);
        end_test("ALU operations", e0);

        // Partial length, tail of v6 keeps its old contents
        e0 = errors;
        run_insn(`VEC_OPC_VLD, 3'd1, 3'd0, 3'd0, 32'd48, 2);
        run_insn(`VEC_OPC_VLD, 3'd2, 3'd0, 3'd0, 32'd56, 2);
        run_insn(`VEC_OPC_VLD, 3'd6, 3'd0, 3'd0, 32'd64, 2);
        run_insn(`VEC_OPC_SETVL, 3'd0, 3'd0, 3'd0, 32'd3, 2);
        run_insn(`VEC_OPC_VADD, 3'd6, 3'd1, 3'd2, 32'd0, 2);
        run_insn(`VEC_OPC_SETVL, 3'd0, 3'd0, 3'd0, 32'd8, 2);
        run_insn(`VEC_OPC_VST, 3'd6, 3'd0, 3'd0, 32'd200, 2);
        for (int i = 0; i < 8; i++) begin
            check_val($sformatf("mem[%0d]", 200 + i), i_mem.peek(8'(200 + i)),
                      (i < 3) ? mem_sh[8'(48 + i)] + mem_sh[8'(56 + i)] : mem_sh[8'(64 + i)]);
        end
        run_insn(`VEC_OPC_SETVL, 3'd0, 3'd0, 3'd0, 32'd3, 2);
        run_insn(`VEC_OPC_VST, 3'd6, 3'd0, 3'd0, 32'd220, 2);   // Three words only
        run_insn(`VEC_OPC_SETVL, 3'd0, 3'd0, 3'd0, 32'd8, 2);
        check_mem(0, 255);
        end_test("partial length", e0);

        // Long response stalls, unknown opcode, zero length
        e0 = errors;
        run_insn(6'h3f, 3'd1, 3'd2, 3'd3, 32'd5, 7);
        run_insn(`VEC_OPC_VLD, 3'd7, 3'd0, 3'd0, 32'd80, 7);
        run_insn(`VEC_OPC_VXOR, 3'd0, 3'd7, 3'd6, 32'd0, 7);
        run_insn(`VEC_OPC_VST, 3'd0, 3'd0, 3'd0, 32'd232, 7);
        run_insn(`VEC_OPC_SETVL, 3'd0, 3'd0, 3'd0, 32'd0, 7);
        run_insn(`VEC_OPC_VST, 3'd7, 3'd0, 3'd0, 32'd240, 7);  // vl 0 touches nothing
        run_insn(`VEC_OPC_SETVL, 3'd0, 3'd0, 3'd0, 32'd8, 7);
        run_insn(`VEC_OPC_VST, 3'd1, 3'd0, 3'd0, 32'd248, 7);  // v1 untouched by the unknown op
        check_mem(0, 255);
        end_test("handshake", e0);

        repeat (2) @(posedge clk);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== src/elem_counter.sv ====
`timescale 1ns/10ps

module elem_counter
    import vec_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  vlen_t len,
    output eidx_t idx,
    output logic  busy,
    output logic  last
);

    vlen_t len_q;       // Length captured at start

    // Final element of the walk
    assign last = busy && ({1'b0, idx} == (len_q - vlen_t'(1)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx   <= '0;
            busy  <= 1'b0;
            len_q <= '0;
        end else if (start) begin
            idx   <= '0;
            busy  <= (len != '0);   // Zero length never goes busy
            len_q <= len;
        end else if (busy) begin
            if (last) begin
                busy <= 1'b0;
            end else begin
                idx <= idx + eidx_t'(1);
            end
        end
    end

endmodule

// ==== src/vec_sequencer.sv ====
`timescale 1ns/10ps
`include "vec_macros.svh"

module vec_sequencer
    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      insn_valid,
    input  word_t     insn,
    input  word_t     rs1,
    input  logic      resp_ready,
    input  eidx_t     cnt_idx,
    input  logic      cnt_busy,
    input  logic      cnt_last,
    output logic      insn_ready,
    output logic      resp_valid,
    output vlen_t     resp_vl,
    output logic      cnt_start,
    output vlen_t     cnt_len,
    output vrf_addr_t rd_addr_a,
    output vrf_addr_t rd_addr_b,
    output logic      ld_we,
    output vrf_addr_t ld_waddr,
    output logic      alu_valid,
    output alu_func_e alu_func,
    output vrf_addr_t alu_waddr,
    output logic      mem_re,
    output mem_addr_t mem_raddr,
    output logic      mem_we,
    output mem_addr_t mem_waddr
);

    seq_state_e state, state_nxt;
    vec_op_e    op_q;                // Opcode of the running instruction
    vlen_t      vl_q;                // Current vector length
    vreg_t      vd_q, vs1_q, vs2_q;
    mem_addr_t  base_q;              // rs1 at acceptance

    vec_op_e    insn_op;
    logic       accept;
    logic       insn_elem;           // Incoming op walks the elements
    logic       is_alu, is_ld, is_st;
    logic       issue;               // Element issued this cycle
    logic       issue_q;             // ... and one cycle ago
    mem_addr_t  maddr;
    mem_addr_t  maddr_q;
    vrf_addr_t  waddr_q;

    // Decode ------------------------
    assign insn_op   = vec_op_e'(insn[`VEC_OP_MSB:`VEC_OP_LSB]);
    assign accept    = insn_valid && insn_ready;
    assign insn_elem = insn_op inside {OP_VADD, OP_VSUB, OP_VAND, OP_VOR, OP_VXOR,
                                       OP_VLD, OP_VST};

    assign is_alu = op_q inside {OP_VADD, OP_VSUB, OP_VAND, OP_VOR, OP_VXOR};
    assign is_ld  = (op_q == OP_VLD);
    assign is_st  = (op_q == OP_VST);

    // Handshakes
    assign insn_ready = (state == ST_IDLE);
    assign resp_valid = (state == ST_RESP);
    assign resp_vl    = vl_q;            // Held, so stable while waiting

    // Counter kicked off in the accept cycle, idx 0 lands in the first run cycle
    assign cnt_start = accept && insn_elem;
    assign cnt_len   = vl_q;

    assign issue = (state == ST_RUN) && cnt_busy;

    // FSM ---------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    // setvl and unknown ops spend one cycle in drain
                    state_nxt = insn_elem ? ST_RUN : ST_DRAIN;
                end
            end
            ST_RUN: begin
                if (!cnt_busy || cnt_last) begin   // vl of 0 falls straight through
                    state_nxt = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // ALU writeback of the last element happens in this cycle at most
                if (!issue_q) begin
                    state_nxt = ST_RESP;
                end
            end
            ST_RESP: begin
                if (resp_ready) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            op_q    <= OP_SETVL;         // No element traffic
            vl_q    <= vlen_t'(`VEC_LANES);
            issue_q <= 1'b0;
        end else begin
            state   <= state_nxt;
            issue_q <= issue;
            if (accept) begin
                op_q <= insn_op;
                if (insn_op == OP_SETVL) begin
                    // min(rs1, 8)
                    vl_q <= (rs1 > word_t'(`VEC_LANES)) ? vlen_t'(`VEC_LANES) : rs1[3:0];
                end
            end
        end
    end

    // Operand latch and address delay line
    always_ff @(posedge clk) begin
        if (accept) begin
            vd_q   <= insn[`VEC_VD_MSB:`VEC_VD_LSB];
            vs1_q  <= insn[`VEC_VS1_MSB:`VEC_VS1_LSB];
            vs2_q  <= insn[`VEC_VS2_MSB:`VEC_VS2_LSB];
            base_q <= rs1;
        end
        waddr_q <= {vd_q, cnt_idx};      // Destination element, one cycle late
        maddr_q <= maddr;
    end

    // Issue side --------------------
    assign maddr     = base_q + mem_addr_t'(cnt_idx);
    assign rd_addr_a = is_st ? {vd_q, cnt_idx} : {vs1_q, cnt_idx};  // Store reads vd
    assign rd_addr_b = {vs2_q, cnt_idx};
    assign mem_re    = issue && is_ld;
    assign mem_raddr = maddr;

    // Write side, one cycle behind issue
    assign ld_we     = issue_q && is_ld;  // mem_rdata valid now
    assign ld_waddr  = waddr_q;
    assign alu_valid = issue_q && is_alu; // Operands out of the VRF now
    assign alu_waddr = waddr_q;
    assign mem_we    = issue_q && is_st;
    assign mem_waddr = maddr_q;

    always_comb begin
        case (op_q)
            OP_VSUB: alu_func = ALU_SUB;
            OP_VAND: alu_func = ALU_AND;
            OP_VOR:  alu_func = ALU_OR;
            OP_VXOR: alu_func = ALU_XOR;
            default: alu_func = ALU_ADD;
        endcase
    end

endmodule

// ==== src/vec_shell.sv ====
`timescale 1ns/10ps

module vec_shell
    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      insn_valid,
    input  word_t     insn,
    input  word_t     rs1,
    input  logic      resp_ready,
    input  elem_t     mem_rdata,
    output logic      insn_ready,
    output logic      resp_valid,
    output vlen_t     resp_vl,
    output logic      mem_re,
    output mem_addr_t mem_raddr,
    output logic      mem_we,
    output mem_addr_t mem_waddr,
    output elem_t     mem_wdata
);

    // Counter handshake
    logic      cnt_start;
    vlen_t     cnt_len;
    eidx_t     cnt_idx;
    logic      cnt_busy;
    logic      cnt_last;

    // Register file ports
    vrf_addr_t rd_addr_a;
    vrf_addr_t rd_addr_b;
    elem_t     rd_data_b;
    logic      ld_we;
    vrf_addr_t ld_waddr;

    // ALU issue and writeback
    logic      alu_valid;
    alu_func_e alu_func;
    vrf_addr_t alu_waddr;
    logic      wb_we;
    vrf_addr_t wb_waddr;
    elem_t     wb_data;

    vec_sequencer i_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .insn_valid (insn_valid),
        .insn       (insn),
        .rs1        (rs1),
        .resp_ready (resp_ready),
        .cnt_idx    (cnt_idx),
        .cnt_busy   (cnt_busy),
        .cnt_last   (cnt_last),
        .insn_ready (insn_ready),
        .resp_valid (resp_valid),
        .resp_vl    (resp_vl),
        .cnt_start  (cnt_start),
        .cnt_len    (cnt_len),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .ld_we      (ld_we),
        .ld_waddr   (ld_waddr),
        .alu_valid  (alu_valid),
        .alu_func   (alu_func),
        .alu_waddr  (alu_waddr),
        .mem_re     (mem_re),
        .mem_raddr  (mem_raddr),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr)
    );

    elem_counter i_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .start (cnt_start),
        .len   (cnt_len),
        .idx   (cnt_idx),
        .busy  (cnt_busy),
        .last  (cnt_last)
    );

    // Port A feeds both the ALU and the store data
    vec_regfile i_vrf (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .ld_we     (ld_we),
        .ld_waddr  (ld_waddr),
        .ld_wdata  (mem_rdata),      // Straight from memory
        .wb_we     (wb_we),
        .wb_waddr  (wb_waddr),
        .wb_data   (wb_data),
        .rd_data_a (mem_wdata),
        .rd_data_b (rd_data_b)
    );

    vec_alu i_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (alu_valid),
        .func     (alu_func),
        .waddr_in (alu_waddr),
        .data0    (mem_wdata),       // vs1 on port A
        .data1    (rd_data_b),       // vs2
        .wb_we    (wb_we),
        .wb_waddr (wb_waddr),
        .wb_data  (wb_data)
    );

endmodule

// ==== vrf/vec_regfile.sv ====
`timescale 1ns/10ps
`include "vec_macros.svh"

module vec_regfile
    import vec_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  vrf_addr_t rd_addr_a,
    input  vrf_addr_t rd_addr_b,
    input  logic      ld_we,
    input  vrf_addr_t ld_waddr,
    input  elem_t     ld_wdata,
    input  logic      wb_we,
    input  vrf_addr_t wb_waddr,
    input  elem_t     wb_data,
    output elem_t     rd_data_a,
    output elem_t     rd_data_b
);

    localparam int unsigned DEPTH = `VEC_REGS * `VEC_LANES;   // 64 elements

    elem_t     mem [DEPTH];

    logic      we;
    vrf_addr_t waddr;
    elem_t     wdata;

    // One physical write port, load wins
    assign we    = ld_we || wb_we;
    assign waddr = ld_we ? ld_waddr : wb_waddr;
    assign wdata = ld_we ? ld_wdata : wb_data;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered reads, old data on a same-cycle write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data_a <= '0;
            rd_data_b <= '0;
        end else begin
            rd_data_a <= mem[rd_addr_a];
            rd_data_b <= mem[rd_addr_b];
        end
    end

endmodule
